/* common/dino_cfg.svh */
`ifndef DINO_CFG_SVH
`define DINO_CFG_SVH

// Screen geometry
`define X_SCREEN 320

// Player column and resting row
`define PLAYER_X 52
`define PLAYER_Y_INIT 109

// Rows climbed before the player turns back down
`define JUMP_HEIGHT 60

// Obstacle respawns one sprite width inside the right edge
`define OBSTACLE_X_START (`X_SCREEN - 32)
`define OBSTACLE_Y 114

// Hitbox shared by player and obstacle
`define HB_W 20
`define HB_H 30

// Game ticks a duck lasts
`define DUCK_TICKS 40

// Clocks per game tick
`define TICK_DIV 8

// Clocks per UART oversample tick, 16 of them per bit
`define OS_DIV 2
`define BIT_CLKS (16 * `OS_DIV)

`endif

/* common/dino_game_pkg.sv */
`default_nettype none

package dino_game_pkg;

	// 320 columns need 9 bits
	typedef logic [8:0] x_coord_t;

	// 240 rows fit in 8 bits
	typedef logic [7:0] y_coord_t;

	typedef logic [15:0] score_t;

	typedef enum logic [1:0] {
		JS_RUNNING,
		JS_ASCENDING,
		JS_DESCENDING
	} jump_state_t;

	typedef enum logic {
		GS_PLAYING,
		GS_GAME_OVER
	} game_state_t;

endpackage

`default_nettype wire

/* common/uart_cmd_pkg.sv */
`default_nettype none

package uart_cmd_pkg;

	typedef logic [7:0] byte_t;

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} rx_state_t;

	// ASCII command letters
	typedef enum logic [7:0] {
		CMD_JUMP    = 8'h4A,
		CMD_DUCK    = 8'h44,
		CMD_RESTART = 8'h49
	} cmd_t;

endpackage

`default_nettype wire

/* sim/tb_clock_gen.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
	output logic Clock,
	output logic rst_n
);
	// 40 ns period
	initial begin
		Clock = 1'b0;
		forever #20 Clock = ~Clock;
	end

	// Held low for 8 cycles, released just after an edge
	initial begin
		rst_n = 1'b0;
		repeat (8) @(posedge Clock);
		#2 rst_n = 1'b1;
	end

endmodule

`default_nettype wire

/* sim/tb_dino_game.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dino_cfg.svh"

module tb_dino_game;

	localparam int DRIVE_DLY  = 2;
	localparam int WAIT_LIMIT = 4000;
	localparam int REST       = `PLAYER_Y_INIT;
	localparam int TOP        = `PLAYER_Y_INIT - `JUMP_HEIGHT;
	localparam int X_START    = `OBSTACLE_X_START;
	// ASCII J, D and I
	localparam logic [7:0] BYTE_J = 8'h4A;
	localparam logic [7:0] BYTE_D = 8'h44;
	localparam logic [7:0] BYTE_I = 8'h49;

	wire        Clock;
	wire        rst_n;
	logic       rx;
	wire [7:0]  player_y;
	wire        ducking;
	wire [8:0]  obstacle_x;
	wire [15:0] score;
	wire [15:0] high_score;
	wire        game_over;

	integer seed = 32'h8fd9_2e5a;

	// Reference model, starting from the reset values
	int exp_x = X_START;
	int exp_y = REST;
	int last_x = X_START;
	int exp_score;
	int exp_high;
	int jump_phase;
	int duck_left;
	bit exp_over;
	bit last_duck;
	bit over_due;
	bit pass_due;
	bit jump_armed;
	bit duck_armed;
	bit restart_armed;

	tb_clock_gen i_tb_clock_gen (.Clock(Clock), .rst_n(rst_n));

	dino_game_top i_dino_game_top (
		.Clock(Clock), .rst_n(rst_n), .rx(rx), .player_y(player_y), .ducking(ducking),
		.obstacle_x(obstacle_x), .score(score), .high_score(high_score),
		.game_over(game_over));

	task automatic compare(input logic [31:0] got, input logic [31:0] want, input string what);
		if (got !== want) begin
			$display("** Error at %0t ns: %s is %0d, expected %0d", $time, what, got, want);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic wait_clock(inout int n, input string what);
		@(posedge Clock);
		n++;
		if (n > WAIT_LIMIT) begin
			$display("Timed out after %0d clocks waiting for %s", n, what);
			$display("sim failed");
			$fatal(1);
		end
	endtask

	task automatic hold_line(input logic level, input int clks);
		@(posedge Clock);
		#DRIVE_DLY;
		rx = level;
		repeat (clks - 1) @(posedge Clock);
	endtask

	// 8N1 with LSB first, a short stop bit lets the next frame follow sooner
	task automatic send_byte(input logic [7:0] data, input int stop_clks);
		int i;
		hold_line(1'b0, `BIT_CLKS);
		for (i = 0; i < 8; i++)
			hold_line(data[i], `BIT_CLKS);
		hold_line(1'b1, stop_clks);
	endtask

	function automatic logic [7:0] noise_byte();
		logic [7:0] b;
		b = $random(seed);
		while (b == BYTE_J || b == BYTE_D || b == BYTE_I)
			b = b + 8'd1;
		return b;
	endfunction

	// One game tick as seen through the obstacle moving
	task automatic model_step();
		int old_x;
		compare(exp_over, 0, "obstacle moving in game over");
		old_x = exp_x;
		exp_x = (exp_x <= 1) ? X_START : exp_x - 1;
		// A granted jump shows up as the first row up
		if (jump_phase == 0 && jump_armed && player_y == REST - 1) begin
			jump_armed = 0;
			jump_phase = 1;
		end
		if (jump_phase == 1) begin
			exp_y--;
			if (exp_y == TOP)
				jump_phase = 2;
		end else if (jump_phase == 2) begin
			exp_y++;
			if (exp_y == REST)
				jump_phase = 0;
		end
		if (duck_left > 0)
			duck_left--;
		if (exp_x <= `PLAYER_X + `HB_W && exp_x + `HB_W >= `PLAYER_X
				&& exp_y + `HB_H >= `OBSTACLE_Y && exp_y <= `OBSTACLE_Y + `HB_H)
			over_due = 1;
		else if (old_x > `PLAYER_X && exp_x <= `PLAYER_X)
			pass_due = 1;
	endtask

	// Outputs settle after the rising edge, so compare on the falling one
	always @(negedge Clock) begin
		if (rst_n) begin
			if (over_due) begin
				over_due = 0;
				exp_over = 1;
				if (exp_score > exp_high)
					exp_high = exp_score;
			end else if (pass_due) begin
				pass_due = 0;
				exp_score++;
				exp_x = X_START;
			end else if (exp_over && game_over === 1'b0) begin
				compare(restart_armed, 1, "restart without an I byte");
				restart_armed = 0;
				exp_over = 0;
				exp_score = 0;
				exp_x = X_START;
				exp_y = REST;
				jump_phase = 0;
				duck_left = 0;
			end else if (obstacle_x !== last_x) begin
				model_step();
			end
			if (ducking === 1'b1 && !last_duck) begin
				compare(duck_armed, 1, "duck without an allowed D byte");
				duck_armed = 0;
				duck_left = `DUCK_TICKS;
			end
			compare(obstacle_x, exp_x, "obstacle_x");
			compare(player_y, exp_y, "player_y");
			compare(ducking, duck_left != 0, "ducking");
			compare(score, exp_score, "score");
			compare(high_score, exp_high, "high_score");
			compare(game_over, exp_over, "game_over");
			last_x = obstacle_x;
			last_duck = ducking;
		end
	end

	initial begin
		int r;
		int n;
		int trigger;
		int target;
		bit do_jump;
		rx = 1'b1;
		n = 0;
		while (rst_n !== 1'b1)
			wait_clock(n, "end of reset");
		// Noise and an I byte while playing leave the game alone
		send_byte(noise_byte(), `BIT_CLKS);
		send_byte(BYTE_I, `BIT_CLKS);
		for (r = 0; r < 6; r++) begin
			// J is sent about one frame before the jump has to start
			trigger = 150 + ($random(seed) & 15);
			n = 0;
			while (obstacle_x > trigger)
				wait_clock(n, "obstacle to approach");
			do_jump = (r == 2 || r == 5) ? 1'b0 : (r < 2) ? 1'b1 : $random(seed) & 1;
			repeat ($random(seed) & 7) @(posedge Clock);
			if (do_jump) begin
				compare(jump_phase, 0, "player on the ground before J");
				compare(duck_left, 0, "duck over before J");
				target = exp_score + 1;
				jump_armed = 1;
				send_byte(BYTE_J, `BIT_CLKS);
				n = 0;
				while (jump_phase == 0)
					wait_clock(n, "jump to start");
				// Ignored while airborne
				send_byte(BYTE_D, `BIT_CLKS);
				n = 0;
				while (exp_score != target)
					wait_clock(n, "obstacle to be cleared");
			end else begin
				send_byte(noise_byte(), `BIT_CLKS);
				n = 0;
				while (!exp_over)
					wait_clock(n, "game over");
				repeat (40 + ($random(seed) & 63)) @(posedge Clock);
				restart_armed = 1;
				send_byte(BYTE_I, `BIT_CLKS);
				n = 0;
				while (exp_over)
					wait_clock(n, "restart");
				// D then a J that arrives a tick or two before the duck ends
				duck_armed = 1;
				send_byte(BYTE_D, 24);
				send_byte(BYTE_J, `BIT_CLKS);
				n = 0;
				while (duck_left != 0 || ducking)
					wait_clock(n, "duck to end");
			end
		end
		$display("sim passed");
		$finish;
	end

endmodule

`default_nettype wire

/* src/dino_game_top.sv */
`timescale 1ns/1ps
`default_nettype none

module dino_game_top (
	input  wire                      Clock,
	input  wire                      rst_n,
	input  wire                      rx,
	output dino_game_pkg::y_coord_t  player_y,
	output logic                     ducking,
	output dino_game_pkg::x_coord_t  obstacle_x,
	output dino_game_pkg::score_t    score,
	output dino_game_pkg::score_t    high_score,
	output logic                     game_over
);
	import uart_cmd_pkg::*;

	logic  rx_valid;
	byte_t rx_data;
	logic  jump_cmd;
	logic  duck_cmd;
	logic  restart_cmd;
	logic  game_tick;
	logic  respawn;
	logic  restart;

	uart_rx i_uart_rx (
		.Clock(Clock), .rst_n(rst_n), .rx(rx),
		.rx_valid(rx_valid), .rx_data(rx_data));

	uart_cmd_decoder i_uart_cmd_decoder (
		.Clock(Clock), .rst_n(rst_n), .rx_valid(rx_valid), .rx_data(rx_data),
		.jump_cmd(jump_cmd), .duck_cmd(duck_cmd), .restart_cmd(restart_cmd));

	player_motion i_player_motion (
		.Clock(Clock), .rst_n(rst_n), .game_tick(game_tick), .restart(restart),
		.jump_cmd(jump_cmd), .duck_cmd(duck_cmd),
		.player_y(player_y), .ducking(ducking));

	obstacle_motion i_obstacle_motion (
		.Clock(Clock), .rst_n(rst_n), .game_tick(game_tick), .respawn(respawn),
		.restart(restart), .obstacle_x(obstacle_x));

	game_ctrl i_game_ctrl (
		.Clock(Clock), .rst_n(rst_n), .restart_cmd(restart_cmd),
		.player_y(player_y), .obstacle_x(obstacle_x),
		.game_tick(game_tick), .respawn(respawn), .restart(restart),
		.score(score), .high_score(high_score), .game_over(game_over));

endmodule

`default_nettype wire

/* src/game_ctrl.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dino_cfg.svh"

module game_ctrl (
	input  wire                          Clock,
	input  wire                          rst_n,
	input  wire                          restart_cmd,
	input  wire dino_game_pkg::y_coord_t player_y,
	input  wire dino_game_pkg::x_coord_t obstacle_x,
	output logic                         game_tick,
	output logic                         respawn,
	output logic                         restart,
	output dino_game_pkg::score_t        score,
	output dino_game_pkg::score_t        high_score,
	output logic                         game_over
);
	import dino_game_pkg::*;

	localparam int TICK_W = $clog2(`TICK_DIV);
	localparam x_coord_t PLAYER_COL = x_coord_t'(`PLAYER_X);

	logic [TICK_W-1:0] tick_cnt;
	game_state_t       game_state;
	x_coord_t          prev_x;
	logic [9:0]        ox_ext;
	logic [8:0]        py_ext;
	logic              hit;
	logic              pass;

	always_ff @(posedge Clock) begin
		if (!rst_n || game_tick)
			tick_cnt <= '0;
		else
			tick_cnt <= tick_cnt + 1'b1;
	end

	// No tick during game over, so everything freezes
	assign game_tick = (game_state == GS_PLAYING) && (tick_cnt == TICK_W'(`TICK_DIV - 1));

	assign ox_ext = {1'b0, obstacle_x};
	assign py_ext = {1'b0, player_y};

	assign hit = (game_state == GS_PLAYING)
		&& (10'(`PLAYER_X + `HB_W) >= ox_ext)
		&& (10'(`PLAYER_X) <= ox_ext + 10'(`HB_W))
		&& (py_ext + 9'(`HB_H) >= 9'(`OBSTACLE_Y))
		&& (py_ext <= 9'(`OBSTACLE_Y + `HB_H));

	assign pass = (game_state == GS_PLAYING) && !hit
		&& (prev_x > PLAYER_COL) && (obstacle_x <= PLAYER_COL);

	assign respawn = pass;
	assign restart = restart_cmd && (game_state == GS_GAME_OVER);
	assign game_over = (game_state == GS_GAME_OVER);

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			game_state <= GS_PLAYING;
			prev_x     <= x_coord_t'(`OBSTACLE_X_START);
			score      <= '0;
			high_score <= '0;
		end else begin
			prev_x <= obstacle_x;
			if (restart) begin
				game_state <= GS_PLAYING;
				score      <= '0;
			end else if (hit) begin
				game_state <= GS_GAME_OVER;
				if (score > high_score)
					high_score <= score;
			end else if (pass) begin
				score <= score + 1'b1;
			end
		end
	end

	a_score_frozen: assert property (@(posedge Clock) disable iff (!rst_n)
		(game_state == GS_GAME_OVER && !restart) |=> $stable(score));

endmodule

`default_nettype wire

/* src/obstacle_motion.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dino_cfg.svh"

module obstacle_motion (
	input  wire                      Clock,
	input  wire                      rst_n,
	input  wire                      game_tick,
	input  wire                      respawn,
	input  wire                      restart,
	output dino_game_pkg::x_coord_t  obstacle_x
);
	import dino_game_pkg::*;

	localparam x_coord_t X_START = x_coord_t'(`OBSTACLE_X_START);

	x_coord_t x_step;

	// Wrap once the left edge is reached
	always_comb begin
		if (obstacle_x <= 9'd1)
			x_step = X_START;
		else
			x_step = obstacle_x - 1'b1;
	end

	always_ff @(posedge Clock) begin
		if (!rst_n)
			obstacle_x <= X_START;
		else if (respawn || restart)
			obstacle_x <= X_START;
		else if (game_tick)
			obstacle_x <= x_step;
	end

endmodule

`default_nettype wire

/* src/player_motion.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dino_cfg.svh"

module player_motion (
	input  wire                      Clock,
	input  wire                      rst_n,
	input  wire                      game_tick,
	input  wire                      restart,
	input  wire                      jump_cmd,
	input  wire                      duck_cmd,
	output dino_game_pkg::y_coord_t  player_y,
	output logic                     ducking
);
	import dino_game_pkg::*;

	localparam y_coord_t Y_REST = y_coord_t'(`PLAYER_Y_INIT);
	localparam y_coord_t Y_TOP  = y_coord_t'(`PLAYER_Y_INIT - `JUMP_HEIGHT);
	localparam int DUCK_W = $clog2(`DUCK_TICKS + 1);

	jump_state_t       jump_state;
	logic [DUCK_W-1:0] duck_timer;

	always_ff @(posedge Clock) begin
		if (!rst_n || restart) begin
			jump_state <= JS_RUNNING;
			player_y   <= Y_REST;
		end else begin
			case (jump_state)
				JS_RUNNING: if (jump_cmd && !ducking)
					jump_state <= JS_ASCENDING;
				JS_ASCENDING: if (game_tick) begin
					player_y <= player_y - 1'b1;
					if (player_y == Y_TOP + 8'd1)
						jump_state <= JS_DESCENDING;
				end
				JS_DESCENDING: if (game_tick) begin
					player_y <= player_y + 1'b1;
					if (player_y == Y_REST - 8'd1)
						jump_state <= JS_RUNNING;
				end
				default: jump_state <= JS_RUNNING;
			endcase
		end
	end

	// Ducking only from the ground, a new duck restarts the timer
	always_ff @(posedge Clock) begin
		if (!rst_n || restart)
			duck_timer <= '0;
		else if (duck_cmd && jump_state == JS_RUNNING)
			duck_timer <= DUCK_W'(`DUCK_TICKS);
		else if (game_tick && duck_timer != '0)
			duck_timer <= duck_timer - 1'b1;
	end

	assign ducking = (duck_timer != '0);

	a_y_range: assert property (@(posedge Clock) disable iff (!rst_n)
		player_y <= Y_REST && player_y >= Y_TOP);

endmodule

`default_nettype wire

/* tb.f */
+incdir+common
common/uart_cmd_pkg.sv
common/dino_game_pkg.sv
uart/uart_rx.sv
uart/uart_cmd_decoder.sv
src/player_motion.sv
src/obstacle_motion.sv
src/game_ctrl.sv
src/dino_game_top.sv
sim/tb_clock_gen.sv
sim/tb_dino_game.sv

/* uart/uart_cmd_decoder.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_cmd_decoder (
	input  wire                 Clock,
	input  wire                 rst_n,
	input  wire                 rx_valid,
	input  wire uart_cmd_pkg::byte_t rx_data,
	output logic                jump_cmd,
	output logic                duck_cmd,
	output logic                restart_cmd
);
	import uart_cmd_pkg::*;

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			jump_cmd    <= 1'b0;
			duck_cmd    <= 1'b0;
			restart_cmd <= 1'b0;
		end else begin
			jump_cmd    <= 1'b0;
			duck_cmd    <= 1'b0;
			restart_cmd <= 1'b0;
			if (rx_valid) begin
				case (rx_data)
					CMD_JUMP:    jump_cmd    <= 1'b1;
					CMD_DUCK:    duck_cmd    <= 1'b1;
					CMD_RESTART: restart_cmd <= 1'b1;
					// Anything else is line noise
					default: ;
				endcase
			end
		end
	end

	a_one_cmd: assert property (@(posedge Clock) disable iff (!rst_n)
		$onehot0({jump_cmd, duck_cmd, restart_cmd}));

endmodule

`default_nettype wire

/* uart/uart_rx.sv */
`timescale 1ns/1ps
`default_nettype none

`include "dino_cfg.svh"

module uart_rx (
	input  wire                 Clock,
	input  wire                 rst_n,
	input  wire                 rx,
	output logic                rx_valid,
	output uart_cmd_pkg::byte_t rx_data
);
	import uart_cmd_pkg::*;

	localparam int OS_W = $clog2(`OS_DIV);

	logic            rx_meta;
	logic            rx_sync;
	logic [OS_W-1:0] os_cnt;
	logic            os_tick;
	rx_state_t       state;
	logic [3:0]      sample_cnt;
	logic [2:0]      bit_cnt;
	byte_t           shift;

	// Line idles high
	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			rx_meta <= 1'b1;
			rx_sync <= 1'b1;
		end else begin
			rx_meta <= rx;
			rx_sync <= rx_meta;
		end
	end

	always_ff @(posedge Clock) begin
		if (!rst_n)
			os_cnt <= '0;
		else if (os_tick)
			os_cnt <= '0;
		else
			os_cnt <= os_cnt + 1'b1;
	end

	assign os_tick = (os_cnt == OS_W'(`OS_DIV - 1));

	always_ff @(posedge Clock) begin
		if (!rst_n) begin
			state      <= RX_IDLE;
			sample_cnt <= '0;
			bit_cnt    <= '0;
			rx_valid   <= 1'b0;
		end else begin
			rx_valid <= 1'b0;
			if (os_tick) begin
				case (state)
					RX_IDLE: if (!rx_sync) begin
						state      <= RX_START;
						sample_cnt <= 4'd7;
					end
					RX_START: if (sample_cnt != 4'd0) begin
						sample_cnt <= sample_cnt - 1'b1;
					end else if (!rx_sync) begin
						state      <= RX_DATA;
						sample_cnt <= 4'd15;
						bit_cnt    <= 3'd0;
					end else begin
						// Glitch, not a real start bit
						state <= RX_IDLE;
					end
					RX_DATA: if (sample_cnt != 4'd0) begin
						sample_cnt <= sample_cnt - 1'b1;
					end else begin
						sample_cnt <= 4'd15;
						bit_cnt    <= bit_cnt + 1'b1;
						if (bit_cnt == 3'd7)
							state <= RX_STOP;
					end
					RX_STOP: if (sample_cnt != 4'd0) begin
						sample_cnt <= sample_cnt - 1'b1;
					end else begin
						// Framing error drops the byte
						rx_valid <= rx_sync;
						state    <= RX_IDLE;
					end
					default: state <= RX_IDLE;
				endcase
			end
		end
	end

	// LSB arrives first
	always_ff @(posedge Clock) begin
		if (os_tick && state == RX_DATA && sample_cnt == 4'd0)
			shift <= {rx_sync, shift[7:1]};
		if (os_tick && state == RX_STOP && sample_cnt == 4'd0)
			rx_data <= shift;
	end

	a_valid_single: assert property (@(posedge Clock) disable iff (!rst_n)
		rx_valid |=> !rx_valid);

endmodule

`default_nettype wire
